// ==== ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Register and program counter widths
`define EX_XLEN       64
`define EX_ADDR_W     64
`define EX_REGNO_W    5

// Shift amount widths for full-width and word shifts
`define EX_SHAMT_W    6
`define EX_WSHAMT_W   5

// Low half used by the W operations
`define EX_WORD_W     32

// Converts pc_plus4 back to the instruction's own address
`define EX_INSN_BYTES 4

`endif

// ==== ex_pkg.sv ====
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]    xlen_t;
    typedef logic [`EX_ADDR_W-1:0]  addr_t;
    typedef logic [`EX_REGNO_W-1:0] regno_t;

    // OP_NOP must stay at zero, it is the bubble
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,   OP_SUB,   OP_SLL,   OP_SLT,   OP_SLTU,
        OP_XOR,   OP_SRL,   OP_SRA,   OP_OR,    OP_AND,
        OP_ADDI,  OP_SLTI,  OP_SLTIU, OP_XORI,  OP_ORI,
        OP_ANDI,  OP_SLLI,  OP_SRLI,  OP_SRAI,
        OP_ADDW,  OP_SUBW,  OP_SLLW,  OP_SRLW,  OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LUI,   OP_AUIPC,
        OP_LOAD,  OP_STORE,
        OP_BEQ,   OP_BNE,   OP_BLT,   OP_BGE,   OP_BLTU,  OP_BGEU,
        OP_JAL,   OP_JALR
    } ex_op_t;

    typedef enum logic {
        STALL_IDLE,
        STALL_WAIT
    } stall_state_t;

endpackage

// ==== operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward
    import ex_pkg::*;
(
    input  regno_t regno,
    input  xlen_t  reg_value,
    input  logic   use_mm_data,
    input  regno_t alu_rd_regno,
    input  logic   alu_update_rd,
    input  logic   alu_mm_load,
    input  xlen_t  alu_result_fwd,
    input  regno_t mm_rd_regno,
    input  logic   mm_update_rd,
    input  logic   mm_mm_load,
    input  xlen_t  mm_alu_result,
    input  xlen_t  mm_data,
    input  regno_t wb_rd_regno,
    input  logic   wb_update_rd,
    input  xlen_t  wb_data,
    output xlen_t  value,
    output logic   load_hazard
);

    logic is_x0;
    logic alu_match;
    logic mm_match;
    logic wb_match;

    assign is_x0     = (regno == '0);
    assign alu_match = (regno == alu_rd_regno);
    assign mm_match  = (regno == mm_rd_regno);
    assign wb_match  = (regno == wb_rd_regno);

    // Load still in the ALU stage, data not there yet
    assign load_hazard = !is_x0 && alu_match && alu_mm_load;

    // Youngest producer wins
    always_comb
    begin
        if (is_x0)
            value = '0;
        else if (alu_match && alu_mm_load)
            value = use_mm_data ? mm_data : reg_value;
        else if (alu_match && alu_update_rd)
            value = alu_result_fwd;
        else if (mm_match && mm_mm_load)
            value = mm_data;
        else if (mm_match && mm_update_rd)
            value = mm_alu_result;
        else if (wb_match && wb_update_rd)
            value = wb_data;
        else
            value = reg_value;
    end

endmodule

// ==== load_use_stall.sv ====
`timescale 1ns/1ps

module load_use_stall
    import ex_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic syscall_flush,
    input  logic hazard,
    output logic ready,
    output logic use_mm_data
);

    stall_state_t state;
    stall_state_t state_next;

    assign ready       = !((state == STALL_IDLE) && enable && hazard);
    assign use_mm_data = (state == STALL_WAIT);

    always_comb
    begin
        state_next = state;
        if (syscall_flush)
            state_next = STALL_IDLE;
        else if (state == STALL_IDLE && enable && hazard)
            state_next = STALL_WAIT;
        // Ready is always high while waiting, so enable means accept
        else if (state == STALL_WAIT && enable)
            state_next = STALL_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= STALL_IDLE;
        else
            state <= state_next;
    end

endmodule

// ==== alu_core.sv ====
`timescale 1ns/1ps
`include "ex_params.svh"

module alu_core
    import ex_pkg::*;
(
    input  ex_op_t op,
    input  xlen_t  value1,
    input  xlen_t  value2,
    input  xlen_t  imm_value,
    input  addr_t  pc_plus4,
    output xlen_t  result
);

    localparam int WORD_W = `EX_WORD_W;

    logic  is_imm;
    xlen_t operand2;

    function automatic xlen_t sext_word(input logic [WORD_W-1:0] word);
        return {{(`EX_XLEN-WORD_W){word[WORD_W-1]}}, word};
    endfunction

    // Immediate forms share the datapath of their register forms
    assign is_imm = op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                               OP_SLLI, OP_SRLI, OP_SRAI,
                               OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
    assign operand2 = is_imm ? imm_value : value2;

    always_comb
    begin
        case (op)
            OP_ADD, OP_ADDI:
                result = value1 + operand2;
            OP_SUB:
                result = value1 - operand2;
            OP_SLL, OP_SLLI:
                result = value1 << operand2[`EX_SHAMT_W-1:0];
            OP_SLT, OP_SLTI:
                result = xlen_t'($signed(value1) < $signed(operand2));
            OP_SLTU, OP_SLTIU:
                result = xlen_t'(value1 < operand2);
            OP_XOR, OP_XORI:
                result = value1 ^ operand2;
            OP_SRL, OP_SRLI:
                result = value1 >> operand2[`EX_SHAMT_W-1:0];
            OP_SRA, OP_SRAI:
                result = $signed(value1) >>> operand2[`EX_SHAMT_W-1:0];
            OP_OR, OP_ORI:
                result = value1 | operand2;
            OP_AND, OP_ANDI:
                result = value1 & operand2;
            // Word forms work on the low half, then sign-extend
            OP_ADDW, OP_ADDIW:
                result = sext_word(value1[WORD_W-1:0] + operand2[WORD_W-1:0]);
            OP_SUBW:
                result = sext_word(value1[WORD_W-1:0] - operand2[WORD_W-1:0]);
            OP_SLLW, OP_SLLIW:
                result = sext_word(value1[WORD_W-1:0] << operand2[`EX_WSHAMT_W-1:0]);
            OP_SRLW, OP_SRLIW:
                result = sext_word(value1[WORD_W-1:0] >> operand2[`EX_WSHAMT_W-1:0]);
            OP_SRAW, OP_SRAIW:
                result = sext_word($signed(value1[WORD_W-1:0]) >>> operand2[`EX_WSHAMT_W-1:0]);
            OP_LUI:
                result = imm_value;
            OP_AUIPC:
                result = pc_plus4 - `EX_INSN_BYTES + imm_value;
            // Link value
            OP_JAL, OP_JALR:
                result = pc_plus4;
            // Effective address
            OP_LOAD, OP_STORE:
                result = value1 + imm_value;
            default:
                result = '0;
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_params.svh"

module branch_unit
    import ex_pkg::*;
(
    input  ex_op_t op,
    input  xlen_t  value1,
    input  xlen_t  value2,
    input  xlen_t  imm_value,
    input  addr_t  pc_plus4,
    output logic   taken,
    output addr_t  target_pc
);

    logic  equal;
    logic  less_signed;
    logic  less_unsigned;
    addr_t pc_rel_target;
    xlen_t jump_sum;

    assign equal         = (value1 == value2);
    assign less_signed   = ($signed(value1) < $signed(value2));
    assign less_unsigned = (value1 < value2);

    assign pc_rel_target = pc_plus4 - `EX_INSN_BYTES + imm_value;
    assign jump_sum      = value1 + imm_value;

    always_comb
    begin
        case (op)
            OP_BEQ:           taken = equal;
            OP_BNE:           taken = !equal;
            OP_BLT:           taken = less_signed;
            OP_BGE:           taken = !less_signed;
            OP_BLTU:          taken = less_unsigned;
            OP_BGEU:          taken = !less_unsigned;
            OP_JAL, OP_JALR:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (!taken)
            target_pc = pc_plus4;
        else if (op == OP_JALR)
            target_pc = {jump_sum[`EX_ADDR_W-1:1], 1'b0};
        else
            target_pc = pc_rel_target;
    end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  ex_op_t op,
    input  regno_t rs1_regno,
    input  regno_t rs2_regno,
    input  regno_t rd_regno,
    input  xlen_t  rs1_value,
    input  xlen_t  rs2_value,
    input  xlen_t  imm_value,
    input  addr_t  pc_plus4,
    input  regno_t alu_rd_regno,
    input  logic   alu_update_rd,
    input  logic   alu_mm_load,
    input  xlen_t  alu_result_fwd,
    input  regno_t mm_rd_regno,
    input  logic   mm_update_rd,
    input  logic   mm_mm_load,
    input  xlen_t  mm_alu_result,
    input  xlen_t  mm_data,
    input  regno_t wb_rd_regno,
    input  logic   wb_update_rd,
    input  xlen_t  wb_data,
    input  logic   syscall_flush,
    input  logic   branch_flush,
    output xlen_t  out_alu_result,
    output xlen_t  out_store_data,
    output regno_t out_rd_regno,
    output ex_op_t out_op,
    output addr_t  out_target_pc,
    output logic   out_update_rd,
    output logic   out_branch_taken,
    output logic   out_mm_load,
    output logic   ready
);

    xlen_t value1;
    xlen_t value2;
    logic  hazard_rs1;
    logic  hazard_rs2;
    logic  use_mm_data;
    xlen_t alu_result;
    logic  branch_taken;
    addr_t target_pc;
    logic  update_rd;
    logic  mm_load;
    logic  accept;

    operand_forward u_fwd_rs1 (
        .regno          (rs1_regno),
        .reg_value      (rs1_value),
        .use_mm_data    (use_mm_data),
        .alu_rd_regno   (alu_rd_regno),
        .alu_update_rd  (alu_update_rd),
        .alu_mm_load    (alu_mm_load),
        .alu_result_fwd (alu_result_fwd),
        .mm_rd_regno    (mm_rd_regno),
        .mm_update_rd   (mm_update_rd),
        .mm_mm_load     (mm_mm_load),
        .mm_alu_result  (mm_alu_result),
        .mm_data        (mm_data),
        .wb_rd_regno    (wb_rd_regno),
        .wb_update_rd   (wb_update_rd),
        .wb_data        (wb_data),
        .value          (value1),
        .load_hazard    (hazard_rs1)
    );

    operand_forward u_fwd_rs2 (
        .regno          (rs2_regno),
        .reg_value      (rs2_value),
        .use_mm_data    (use_mm_data),
        .alu_rd_regno   (alu_rd_regno),
        .alu_update_rd  (alu_update_rd),
        .alu_mm_load    (alu_mm_load),
        .alu_result_fwd (alu_result_fwd),
        .mm_rd_regno    (mm_rd_regno),
        .mm_update_rd   (mm_update_rd),
        .mm_mm_load     (mm_mm_load),
        .mm_alu_result  (mm_alu_result),
        .mm_data        (mm_data),
        .wb_rd_regno    (wb_rd_regno),
        .wb_update_rd   (wb_update_rd),
        .wb_data        (wb_data),
        .value          (value2),
        .load_hazard    (hazard_rs2)
    );

    load_use_stall u_stall (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .syscall_flush (syscall_flush),
        .hazard        (hazard_rs1 || hazard_rs2),
        .ready         (ready),
        .use_mm_data   (use_mm_data)
    );

    alu_core u_alu (
        .op        (op),
        .value1    (value1),
        .value2    (value2),
        .imm_value (imm_value),
        .pc_plus4  (pc_plus4),
        .result    (alu_result)
    );

    branch_unit u_branch (
        .op        (op),
        .value1    (value1),
        .value2    (value2),
        .imm_value (imm_value),
        .pc_plus4  (pc_plus4),
        .taken     (branch_taken),
        .target_pc (target_pc)
    );

    // Stores, branches, loads and the bubble leave rd alone
    assign update_rd = !(op inside {OP_NOP, OP_LOAD, OP_STORE, OP_BEQ, OP_BNE,
                                    OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});
    assign mm_load   = (op == OP_LOAD);
    assign accept    = enable && ready;

    always_ff @(posedge clk)
    begin
        if (reset || syscall_flush || (enable && !ready) || (accept && branch_flush))
        begin
            // Bubble
            out_alu_result   <= '0;
            out_store_data   <= '0;
            out_rd_regno     <= '0;
            out_op           <= OP_NOP;
            out_target_pc    <= '0;
            out_update_rd    <= 1'b0;
            out_branch_taken <= 1'b0;
            out_mm_load      <= 1'b0;
        end
        else if (accept)
        begin
            out_alu_result   <= alu_result;
            out_store_data   <= value2;
            out_rd_regno     <= rd_regno;
            out_op           <= op;
            out_target_pc    <= target_pc;
            out_update_rd    <= update_rd;
            out_branch_taken <= branch_taken;
            out_mm_load      <= mm_load;
        end
    end

endmodule

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    // Longest test sequence takes a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic   clk;
    logic   reset;
    logic   enable;
    logic   syscall_flush;
    logic   branch_flush;
    ex_op_t op;
    regno_t rs1_regno;
    regno_t rs2_regno;
    regno_t rd_regno;
    regno_t alu_rd_regno;
    regno_t mm_rd_regno;
    regno_t wb_rd_regno;
    xlen_t  rs1_value;
    xlen_t  rs2_value;
    xlen_t  imm_value;
    xlen_t  alu_result_fwd;
    xlen_t  mm_alu_result;
    xlen_t  mm_data;
    xlen_t  wb_data;
    addr_t  pc_plus4;
    logic   alu_update_rd;
    logic   alu_mm_load;
    logic   mm_update_rd;
    logic   mm_mm_load;
    logic   wb_update_rd;
    xlen_t  out_alu_result;
    xlen_t  out_store_data;
    regno_t out_rd_regno;
    ex_op_t out_op;
    addr_t  out_target_pc;
    logic   out_update_rd;
    logic   out_branch_taken;
    logic   out_mm_load;
    logic   ready;
    int     cycles = 0;

    ex_stage u_ex_stage (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Testbench failed");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic xlen_t random_value();
        return {$urandom, $urandom};
    endfunction

    function automatic xlen_t model_result(ex_op_t o, xlen_t a, xlen_t b, xlen_t imm, addr_t pc);
        xlen_t       s;
        logic [31:0] w;
        s = (o inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI,
                       OP_SRAI, OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW}) ? imm : b;
        case (o)
            OP_ADD, OP_ADDI:     return a + s;
            OP_SUB:              return a - s;
            OP_SLL, OP_SLLI:     return a << s[5:0];
            OP_SLT, OP_SLTI:     return xlen_t'($signed(a) < $signed(s));
            OP_SLTU, OP_SLTIU:   return xlen_t'(a < s);
            OP_XOR, OP_XORI:     return a ^ s;
            OP_SRL, OP_SRLI:     return a >> s[5:0];
            OP_SRA, OP_SRAI:     return $signed(a) >>> s[5:0];
            OP_OR, OP_ORI:       return a | s;
            OP_AND, OP_ANDI:     return a & s;
            OP_ADDW, OP_ADDIW:   w = a[31:0] + s[31:0];
            OP_SUBW:             w = a[31:0] - s[31:0];
            OP_SLLW, OP_SLLIW:   w = a[31:0] << s[4:0];
            OP_SRLW, OP_SRLIW:   w = a[31:0] >> s[4:0];
            OP_SRAW, OP_SRAIW:   w = $signed(a[31:0]) >>> s[4:0];
            OP_LUI:              return imm;
            OP_AUIPC:            return pc - 4 + imm;
            OP_JAL, OP_JALR:     return pc;
            OP_LOAD, OP_STORE:   return a + imm;
            default:             return '0;
        endcase
        // Only the word forms get here
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic model_taken(ex_op_t o, xlen_t a, xlen_t b);
        case (o)
            OP_BEQ:          return a == b;
            OP_BNE:          return a != b;
            OP_BLT:          return $signed(a) < $signed(b);
            OP_BGE:          return $signed(a) >= $signed(b);
            OP_BLTU:         return a < b;
            OP_BGEU:         return a >= b;
            OP_JAL, OP_JALR: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic addr_t model_target(ex_op_t o, xlen_t a, xlen_t b, xlen_t imm, addr_t pc);
        if (!model_taken(o, a, b))
            return pc;
        if (o == OP_JALR)
            return (a + imm) & ~64'd1;
        return pc - 4 + imm;
    endfunction

    task automatic check_equal(input xlen_t got, input xlen_t expected, input string msg);
        if (got !== expected)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, msg, got, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs(input xlen_t v1, input xlen_t v2);
        string name;
        name = op.name();
        check_equal(out_alu_result, model_result(op, v1, v2, imm_value, pc_plus4),
                    {name, " out_alu_result"});
        check_equal(out_target_pc, model_target(op, v1, v2, imm_value, pc_plus4),
                    {name, " out_target_pc"});
        check_equal(out_branch_taken, model_taken(op, v1, v2), {name, " out_branch_taken"});
        check_equal(out_update_rd, (op >= OP_ADD && op <= OP_AUIPC) || op == OP_JAL ||
                    op == OP_JALR, {name, " out_update_rd"});
        check_equal(out_mm_load, op == OP_LOAD, {name, " out_mm_load"});
        check_equal(out_store_data, v2, {name, " out_store_data"});
        check_equal(out_op, op, {name, " out_op"});
        check_equal(out_rd_regno, rd_regno, {name, " out_rd_regno"});
    endtask

    task automatic clear_forwarding();
        alu_rd_regno   = '0;
        alu_update_rd  = 1'b0;
        alu_mm_load    = 1'b0;
        alu_result_fwd = '0;
        mm_rd_regno    = '0;
        mm_update_rd   = 1'b0;
        mm_mm_load     = 1'b0;
        mm_alu_result  = '0;
        mm_data        = '0;
        wb_rd_regno    = '0;
        wb_update_rd   = 1'b0;
        wb_data        = '0;
    endtask

    task automatic drive_op(input ex_op_t o, input regno_t r1, input regno_t r2, input regno_t rd,
                            input xlen_t v1, input xlen_t v2, input xlen_t imm, input addr_t pc);
        op        = o;
        rs1_regno = r1;
        rs2_regno = r2;
        rd_regno  = rd;
        rs1_value = v1;
        rs2_value = v2;
        imm_value = imm;
        pc_plus4  = pc;
        enable    = 1'b1;
    endtask

    // Waits for the accepting edge, then samples one cycle later
    task automatic finish_op();
        @(negedge clk);
        while (!ready)
        begin
            @(posedge clk);
            @(negedge clk);
        end
        @(posedge clk);
        #1 enable = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_equal(ready, 1'b1, "ready after reset");
        check_equal(out_op, OP_NOP, "out_op after reset");
        check_equal(out_update_rd, 1'b0, "out_update_rd after reset");
        check_equal(out_branch_taken, 1'b0, "out_branch_taken after reset");
        check_equal(out_mm_load, 1'b0, "out_mm_load after reset");
        check_equal(out_alu_result, '0, "out_alu_result after reset");
        check_equal(out_store_data, '0, "out_store_data after reset");
        check_equal(out_target_pc, '0, "out_target_pc after reset");
        check_equal(out_rd_regno, '0, "out_rd_regno after reset");
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu_ops();
        for (int i = OP_ADD; i <= OP_STORE; i++)
        begin
            drive_op(ex_op_t'(i), 5'd1, 5'd2, 5'd10, random_value(), random_value(),
                     random_value(), random_value() & ~64'h3);
            finish_op();
            check_outputs(rs1_value, rs2_value);
        end
    endtask

    task automatic forward_case(input regno_t alu_rd, input regno_t mm_rd, input logic mm_is_load,
                                input regno_t wb_rd, input regno_t r1, input xlen_t exp_v1);
        alu_rd_regno  = alu_rd;
        alu_update_rd = 1'b1;
        mm_rd_regno   = mm_rd;
        mm_update_rd  = !mm_is_load;
        mm_mm_load    = mm_is_load;
        wb_rd_regno   = wb_rd;
        wb_update_rd  = 1'b1;
        drive_op(OP_ADD, r1, 5'd9, 5'd4, 64'h1111_0000_0000_1111, 64'h0000_0042_0000_0042,
                 '0, 64'h1000);
        finish_op();
        check_outputs(exp_v1, rs2_value);
    endtask

    task automatic test_forwarding();
        alu_result_fwd = 64'hA1A1_0000_0000_00A1;
        mm_alu_result  = 64'hB2B2_0000_0000_00B2;
        mm_data        = 64'hC3C3_0000_0000_00C3;
        wb_data        = 64'hD4D4_0000_0000_00D4;
        forward_case(5'd7, 5'd7, 1'b0, 5'd7, 5'd7, alu_result_fwd);
        forward_case(5'd3, 5'd7, 1'b0, 5'd7, 5'd7, mm_alu_result);
        forward_case(5'd3, 5'd3, 1'b0, 5'd7, 5'd7, wb_data);
        forward_case(5'd3, 5'd3, 1'b0, 5'd3, 5'd7, 64'h1111_0000_0000_1111);
        forward_case(5'd3, 5'd7, 1'b1, 5'd7, 5'd7, mm_data);
        forward_case(5'd0, 5'd0, 1'b0, 5'd0, 5'd0, '0);
        clear_forwarding();
    endtask

    task automatic test_load_use();
        alu_rd_regno = 5'd5;
        alu_mm_load  = 1'b1;
        mm_data      = random_value();
        drive_op(OP_SUB, 5'd1, 5'd5, 5'd12, random_value(), random_value(), '0, 64'h2000);
        @(negedge clk);
        check_equal(ready, 1'b0, "ready in load-use cycle");
        @(posedge clk);
        #1;
        check_equal(out_op, OP_NOP, "bubble after load-use cycle");
        @(negedge clk);
        check_equal(ready, 1'b1, "ready in the cycle after the stall");
        @(posedge clk);
        #1 enable = 1'b0;
        @(posedge clk);
        #1;
        check_outputs(rs1_value, mm_data);
        clear_forwarding();
    endtask

    task automatic test_branches();
        xlen_t lhs;
        xlen_t rhs;
        for (int i = 0; i < 4; i++)
        begin
            // Equal, signed less, signed greater, both less
            lhs = (i == 1) ? -64'd3 : (i == 2) ? 64'd4 : (i == 3) ? 64'd2 : 64'd5;
            rhs = (i == 1) ? 64'd4 : (i == 2) ? -64'd3 : (i == 3) ? 64'd9 : 64'd5;
            for (int j = OP_BEQ; j <= OP_JALR; j++)
            begin
                drive_op(ex_op_t'(j), 5'd1, 5'd2, 5'd6, lhs, rhs, random_value() | 64'h1,
                         random_value() & ~64'h3);
                finish_op();
                if (op == OP_JALR)
                    check_equal(out_target_pc[0], 1'b0, "jalr target bit 0");
                check_outputs(lhs, rhs);
            end
        end
    endtask

    task automatic test_flushes();
        drive_op(OP_ORI, 5'd1, 5'd2, 5'd8, random_value(), random_value(), 64'h7F, 64'h3000);
        finish_op();
        check_outputs(rs1_value, rs2_value);
        syscall_flush = 1'b1;
        @(posedge clk);
        #1 syscall_flush = 1'b0;
        check_equal(out_op, OP_NOP, "bubble after syscall flush");
        check_equal(out_update_rd, 1'b0, "out_update_rd after syscall flush");
        drive_op(OP_ADD, 5'd1, 5'd2, 5'd8, random_value(), random_value(), '0, 64'h3004);
        finish_op();
        check_outputs(rs1_value, rs2_value);
        drive_op(OP_XOR, 5'd1, 5'd2, 5'd8, random_value(), random_value(), '0, 64'h3008);
        branch_flush = 1'b1;
        @(negedge clk);
        check_equal(ready, 1'b1, "ready during branch flush");
        @(posedge clk);
        #1;
        branch_flush = 1'b0;
        enable       = 1'b0;
        check_equal(out_op, OP_NOP, "bubble after branch flush");
        drive_op(OP_SUB, 5'd1, 5'd2, 5'd8, random_value(), random_value(), '0, 64'h300C);
        finish_op();
        check_outputs(rs1_value, rs2_value);
    endtask

    initial
    begin
        void'($urandom(32'hf3e1_1487));
        reset         = 1'b1;
        enable        = 1'b0;
        syscall_flush = 1'b0;
        branch_flush  = 1'b0;
        op            = OP_NOP;
        rs1_regno     = '0;
        rs2_regno     = '0;
        rd_regno      = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        imm_value     = '0;
        pc_plus4      = '0;
        clear_forwarding();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        test_reset();
        test_alu_ops();
        test_forwarding();
        test_load_use();
        test_branches();
        test_flushes();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
ex_pkg.sv
operand_forward.sv
load_use_stall.sv
alu_core.sv
branch_unit.sv
ex_stage.sv
tb_ex_stage.sv
